//--- rtl/mem_req_pkg.sv
// Built for exactly four requestors and fixed queue depths; payload widths must match the bus.
package mem_req_pkg;

  // --------------------
  // Sizes and thresholds
  // --------------------
  localparam int unsigned num_requestors  = 4;
  localparam int unsigned in_fifo_depth   = 16;
  // Leaves room for grant and input register slack
  localparam int unsigned in_prog_thresh  = 12;
  localparam int unsigned out_fifo_depth  = 32;
  localparam int unsigned out_prog_thresh = 16;

  // --------------------
  // Vector types
  // --------------------
  // Byte address
  typedef logic [31:0] addr_t;
  // Beats per burst
  typedef logic [7:0]  burst_len_t;
  typedef logic [1:0]  requestor_id_t;
  // One bit per requestor
  typedef logic [3:0]  requestor_mask_t;

  // --------------------
  // Encodings
  // --------------------
  typedef enum logic [1:0] {
    cmd_read,
    cmd_write,
    cmd_prefetch
  } mem_cmd_e;

  // Arbiter FSM states
  typedef enum logic [1:0] {
    arb_setup,
    arb_idle,
    arb_grant
  } arb_state_e;

  // --------------------
  // Bundles
  // --------------------
  // 42 bits
  typedef struct packed {
    mem_cmd_e   cmd;
    addr_t      address;
    burst_len_t burst;
  } mem_req_payload_t;

  // Requestor side
  typedef struct packed {
    logic             valid;
    mem_req_payload_t payload;
  } mem_req_t;

  // 44 bits; source sits above the request so the low bits are the bare payload
  typedef struct packed {
    requestor_id_t    source;
    mem_req_payload_t req;
  } mem_req_tagged_payload_t;

  typedef struct packed {
    logic                    valid;
    mem_req_tagged_payload_t payload;
  } mem_req_tagged_t;

  // Memory side drain control
  typedef struct packed {
    logic rd_en;
  } fifo_ctrl_in_t;

  // Queue flags
  typedef struct packed {
    logic empty;
    logic full;
    logic prog_full;
    logic valid;
  } fifo_state_t;

endpackage

//--- rtl/request_fifo.sv
// Depth follows stored_bits: a full tagged width gives the output queue, else an input queue.
`timescale 1ns/1ps

module request_fifo #(
  parameter int unsigned stored_bits = $bits(mem_req_pkg::mem_req_tagged_payload_t)
) (
  input  logic                                 ap_clk,
  input  logic                                 areset_control,
  input  mem_req_pkg::mem_req_tagged_payload_t din,
  input  logic                                 wr_en,
  input  logic                                 rd_en,
  output mem_req_pkg::mem_req_tagged_payload_t dout,
  output mem_req_pkg::fifo_state_t             state
);

  // --------------------
  // Geometry
  // --------------------
  // Full tag width marks the output queue
  localparam bit is_tagged =
    (stored_bits == $bits(mem_req_pkg::mem_req_tagged_payload_t));
  localparam int unsigned depth  =
    is_tagged ? mem_req_pkg::out_fifo_depth : mem_req_pkg::in_fifo_depth;
  localparam int unsigned thresh =
    is_tagged ? mem_req_pkg::out_prog_thresh : mem_req_pkg::in_prog_thresh;
  localparam int unsigned ptr_w  = $clog2(depth);
  localparam int unsigned cnt_w  = $clog2(depth + 1);

  // Storage, no reset
  logic [stored_bits-1:0] mem [depth];
  logic [stored_bits-1:0] dout_q;
  logic [ptr_w-1:0]       wr_ptr;
  logic [ptr_w-1:0]       rd_ptr;
  logic [cnt_w-1:0]       count;
  logic                   rd_valid;
  logic                   do_wr;
  logic                   do_rd;

  // Guard against overflow and underflow
  assign do_wr = wr_en & ~state.full;
  assign do_rd = rd_en & ~state.empty;

  // --------------------
  // Data path
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din[stored_bits-1:0];
    end
    // Read data lands one cycle after the pop
    if (do_rd) begin
      dout_q <= mem[rd_ptr];
    end
  end

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= do_rd;
      if (do_wr) begin
        wr_ptr <= wr_ptr + ptr_w'(1);
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + ptr_w'(1);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + cnt_w'(1);
        2'b01:   count <= count - cnt_w'(1);
        default: count <= count;
      endcase
    end
  end

  // Narrow queues leave the source field zero
  always_comb begin
    dout                  = '0;
    dout[stored_bits-1:0] = dout_q;
  end

  // Flags straight off the count register
  assign state.empty     = (count == '0);
  assign state.full      = (count == cnt_w'(depth));
  assign state.prog_full = (count >= cnt_w'(thresh));
  assign state.valid     = rd_valid;

endmodule

//--- rtl/arbiter_control.sv
// Round-robin over the four input queues; pops stall while the output queue is prog_full.
`timescale 1ns/1ps

module arbiter_control (
  input  logic                         ap_clk,
  input  logic                         areset_control,
  input  mem_req_pkg::fifo_state_t     in_state [mem_req_pkg::num_requestors],
  input  mem_req_pkg::fifo_state_t     out_state,
  output mem_req_pkg::requestor_mask_t pop,
  output mem_req_pkg::requestor_mask_t grant_mask,
  output mem_req_pkg::requestor_mask_t grant_out,
  output logic                         fifo_setup
);

  // Local reset copies
  logic reset_fifo;
  logic reset_arb;

  mem_req_pkg::arb_state_e    state;
  mem_req_pkg::arb_state_e    state_next;
  // Search start
  mem_req_pkg::requestor_id_t rr_ptr;
  mem_req_pkg::requestor_id_t winner;
  logic                       found;
  logic                       can_pop;

  // --------------------
  // Reset distribution
  // --------------------
  always_ff @(posedge ap_clk) begin
    reset_fifo <= areset_control;
    reset_arb  <= areset_control;
  end

  // --------------------
  // Winner search
  // --------------------
  always_comb begin
    mem_req_pkg::requestor_id_t idx;
    found  = 1'b0;
    winner = rr_ptr;
    idx    = rr_ptr;
    // First non-empty queue at or after the pointer
    for (int k = 0; k < mem_req_pkg::num_requestors; k++) begin
      idx = rr_ptr + mem_req_pkg::requestor_id_t'(k);
      if (!found && !in_state[idx].empty) begin
        found  = 1'b1;
        winner = idx;
      end
    end
  end

  // Output queue back-pressure stops arbitration
  assign can_pop = (state != mem_req_pkg::arb_setup) & ~out_state.prog_full;

  // One pop per cycle at most
  always_comb begin
    pop = '0;
    if (found && can_pop) begin
      pop[winner] = 1'b1;
    end
  end

  always_comb begin
    case (state)
      mem_req_pkg::arb_setup: state_next = mem_req_pkg::arb_idle;
      default:                state_next = (|pop) ? mem_req_pkg::arb_grant : mem_req_pkg::arb_idle;
    endcase
  end

  // --------------------
  // FSM and pointer
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (reset_arb) begin
      state      <= mem_req_pkg::arb_setup;
      rr_ptr     <= '0;
      grant_mask <= '0;
      grant_out  <= '0;
    end else begin
      state      <= state_next;
      // Merge uses this to pick the entry popped last cycle
      grant_mask <= pop;
      if (|pop) begin
        rr_ptr <= winner + mem_req_pkg::requestor_id_t'(1);
      end
      // Keep sending only with room both sides
      for (int i = 0; i < mem_req_pkg::num_requestors; i++) begin
        grant_out[i] <= (state != mem_req_pkg::arb_setup) & ~in_state[i].prog_full &
                        ~out_state.prog_full;
      end
    end
  end

  // Setup level covers reset, its echo and the setup state
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      fifo_setup <= 1'b1;
    end else begin
      fifo_setup <= reset_fifo | (state == mem_req_pkg::arb_setup);
    end
  end

endmodule

//--- rtl/request_merge.sv
// Expects a one-hot grant_mask aligned with the read-valid of the popped queue.
`timescale 1ns/1ps

module request_merge (
  input  logic                         ap_clk,
  input  logic                         areset_control,
  input  mem_req_pkg::mem_req_tagged_t in_entry [mem_req_pkg::num_requestors],
  input  mem_req_pkg::requestor_mask_t grant_mask,
  output mem_req_pkg::mem_req_tagged_t merged
);

  logic                                 sel_valid;
  mem_req_pkg::mem_req_tagged_payload_t sel_payload;
  mem_req_pkg::requestor_id_t           sel_id;

  // --------------------
  // Select
  // --------------------
  always_comb begin
    sel_valid   = 1'b0;
    sel_payload = in_entry[0].payload;
    sel_id      = '0;
    // Grant is one-hot so at most one hit
    for (int i = 0; i < mem_req_pkg::num_requestors; i++) begin
      if (grant_mask[i]) begin
        sel_valid   = in_entry[i].valid;
        sel_payload = in_entry[i].payload;
        sel_id      = mem_req_pkg::requestor_id_t'(i);
      end
    end
    // Stamp the winner number
    sel_payload.source = sel_id;
  end

  // --------------------
  // Register toward output queue
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      merged.valid <= 1'b0;
    end else begin
      // Doubles as the output queue write enable
      merged.valid <= sel_valid;
    end
  end

  // Payload carries no reset
  always_ff @(posedge ap_clk) begin
    merged.payload <= sel_payload;
  end

endmodule

//--- rtl/memory_request_arbiter.sv
// Requestors send only after their grant_out bit was high; the output drains on rd_en only.
`timescale 1ns/1ps

module memory_request_arbiter (
  input  logic                         ap_clk,
  input  logic                         areset_control,
  input  mem_req_pkg::mem_req_t        request_in [mem_req_pkg::num_requestors],
  input  mem_req_pkg::fifo_ctrl_in_t   fifo_request_ctrl_in,
  output mem_req_pkg::fifo_state_t     fifo_request_state_out,
  output mem_req_pkg::requestor_mask_t grant_out,
  output mem_req_pkg::mem_req_tagged_t request_out,
  output logic                         fifo_setup
);

  // Input side
  mem_req_pkg::mem_req_t                request_in_reg [mem_req_pkg::num_requestors];
  mem_req_pkg::mem_req_tagged_payload_t in_din         [mem_req_pkg::num_requestors];
  mem_req_pkg::mem_req_tagged_payload_t in_dout        [mem_req_pkg::num_requestors];
  mem_req_pkg::fifo_state_t             in_state       [mem_req_pkg::num_requestors];
  mem_req_pkg::mem_req_tagged_t         in_entry       [mem_req_pkg::num_requestors];

  // Arbitration
  mem_req_pkg::requestor_mask_t pop;
  mem_req_pkg::requestor_mask_t grant_mask;
  mem_req_pkg::mem_req_tagged_t merged;

  // Output side
  mem_req_pkg::fifo_ctrl_in_t           ctrl_reg;
  logic                                 out_rd_en;
  mem_req_pkg::mem_req_tagged_payload_t out_dout;
  mem_req_pkg::fifo_state_t             out_state;
  mem_req_pkg::mem_req_tagged_t         out_stage;

  // --------------------
  // Input registers
  // --------------------
  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < mem_req_pkg::num_requestors; i++) begin
      if (areset_control) begin
        request_in_reg[i].valid <= 1'b0;
      end else begin
        request_in_reg[i].valid <= request_in[i].valid;
      end
      request_in_reg[i].payload <= request_in[i].payload;
    end
  end

  // --------------------
  // Input queues
  // --------------------
  for (genvar g = 0; g < mem_req_pkg::num_requestors; g++) begin : gen_in_queue
    // Source tied to the queue index
    assign in_din[g].source = mem_req_pkg::requestor_id_t'(g);
    assign in_din[g].req    = request_in_reg[g].payload;

    request_fifo #(
      .stored_bits($bits(mem_req_pkg::mem_req_payload_t))
    ) u_in_fifo (
      .ap_clk         (ap_clk),
      .areset_control (areset_control),
      .din            (in_din[g]),
      .wr_en          (request_in_reg[g].valid),
      .rd_en          (pop[g]),
      .dout           (in_dout[g]),
      .state          (in_state[g])
    );

    // Popped entry with its read-valid
    assign in_entry[g].valid   = in_state[g].valid;
    assign in_entry[g].payload = in_dout[g];
  end

  arbiter_control u_arbiter_control (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .in_state       (in_state),
    .out_state      (out_state),
    .pop            (pop),
    .grant_mask     (grant_mask),
    .grant_out      (grant_out),
    .fifo_setup     (fifo_setup)
  );

  request_merge u_request_merge (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .in_entry       (in_entry),
    .grant_mask     (grant_mask),
    .merged         (merged)
  );

  // --------------------
  // Output queue
  // --------------------
  assign out_rd_en = ctrl_reg.rd_en & ~out_state.empty;

  request_fifo u_out_fifo (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .din            (merged.payload),
    .wr_en          (merged.valid),
    .rd_en          (out_rd_en),
    .dout           (out_dout),
    .state          (out_state)
  );

  // Drain control, flags and the two output stages
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ctrl_reg               <= '0;
      fifo_request_state_out <= '{empty: 1'b1, full: 1'b0, prog_full: 1'b0, valid: 1'b0};
      out_stage.valid        <= 1'b0;
      request_out.valid      <= 1'b0;
    end else begin
      ctrl_reg               <= fifo_request_ctrl_in;
      fifo_request_state_out <= out_state;
      out_stage.valid        <= out_state.valid;
      request_out.valid      <= out_stage.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    out_stage.payload   <= out_dout;
    request_out.payload <= out_stage.payload;
  end

endmodule

//--- test/tb_arbiter_table.svh
// Rows run in order after one reset; every row is drained completely before the next row starts.
`ifndef TB_ARBITER_TABLE_SVH
`define TB_ARBITER_TABLE_SVH

// Drain patterns for rd_en
typedef enum logic [1:0] {
  rd_always,
  rd_never,
  rd_alternate
} rd_mode_e;

// --------------------
// Phase row
// --------------------
typedef struct packed {
  // Ten characters, padded with spaces
  logic [79:0] name;
  logic [7:0]  reqs_per_src;
  // Chance of a send per cycle, in percent
  logic [7:0]  send_pct;
  rd_mode_e    rd_mode;
  // Cycles the rd_en pattern holds before the forced drain
  logic [15:0] hold_cycles;
  // grant_out must reach zero while senders still hold entries
  logic        expect_grant_zero;
  // All four send in the same cycles
  logic        lockstep;
  logic        check_rotation;
} phase_row_t;

localparam int num_phases = 5;

// --------------------
// Table
// --------------------
// name, reqs, pct, rd mode, hold, grant zero, lockstep, rotation
function automatic phase_row_t phase_row(input int idx);
  phase_row_t row;
  case (idx)
    0:       row = '{"random_mix", 8'd20, 8'd60, rd_always, 16'd0, 1'b0, 1'b0, 1'b0};
    1:       row = '{"alt_drain ", 8'd16, 8'd80, rd_alternate, 16'd200, 1'b0, 1'b0, 1'b0};
    // Output stalled long enough to fill every queue
    // More requests per source than its queues hold
    2:       row = '{"backpress ", 8'd56, 8'd100, rd_never, 16'd120, 1'b1, 1'b0, 1'b0};
    3:       row = '{"fairness  ", 8'd16, 8'd100, rd_always, 16'd0, 1'b0, 1'b1, 1'b1};
    4:       row = '{"sparse    ", 8'd8, 8'd20, rd_always, 16'd0, 1'b0, 1'b0, 1'b0};
    default: row = '0;
  endcase
  return row;
endfunction

`endif

//--- test/tb_memory_request_arbiter.sv
// Self-checking run over the phase table; assumes payloads never carry X and rows fit 64 per source.
`timescale 1ns/1ps

module tb_memory_request_arbiter;

  `include "tb_arbiter_table.svh"

  localparam int clk_period  = 8;
  localparam int depth_limit = mem_req_pkg::in_fifo_depth + mem_req_pkg::out_fifo_depth;

  logic                         ap_clk;
  logic                         areset_control;
  mem_req_pkg::mem_req_t        request_in [mem_req_pkg::num_requestors];
  mem_req_pkg::fifo_ctrl_in_t   fifo_request_ctrl_in;
  mem_req_pkg::fifo_state_t     fifo_request_state_out;
  mem_req_pkg::requestor_mask_t grant_out;
  mem_req_pkg::mem_req_tagged_t request_out;
  logic                         fifo_setup;

  // Scoreboard, one expected queue per source
  mem_req_pkg::mem_req_payload_t exp_mem [mem_req_pkg::num_requestors][64];
  int unsigned                   sent [mem_req_pkg::num_requestors];
  int unsigned                   received [mem_req_pkg::num_requestors];
  phase_row_t                    cur_row;
  mem_req_pkg::requestor_mask_t  last_grant;
  mem_req_pkg::requestor_id_t    prev_src;
  logic                          have_prev;
  logic                          seen_zero;
  logic                          stall_hold;
  logic                          monitor_on;
  logic                          phase_active;
  logic [31:0]                   lcg_state;
  int unsigned                   check_count;
  int unsigned                   error_count;

  memory_request_arbiter i_dut (
    .ap_clk                 (ap_clk),
    .areset_control         (areset_control),
    .request_in             (request_in),
    .fifo_request_ctrl_in   (fifo_request_ctrl_in),
    .fifo_request_state_out (fifo_request_state_out),
    .grant_out              (grant_out),
    .request_out            (request_out),
    .fifo_setup             (fifo_setup)
  );

  initial begin
    ap_clk = 1'b0;
    forever #(clk_period / 2) ap_clk = ~ap_clk;
  end

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper LCG bits only, the low ones repeat quickly
  function automatic mem_req_pkg::mem_req_payload_t random_payload();
    mem_req_pkg::mem_req_payload_t p;
    logic [31:0]                   r;
    logic [15:0]                   m;
    r         = next_random();
    m         = r[31:16] % 16'd3;
    p.cmd     = mem_req_pkg::mem_cmd_e'(m[1:0]);
    p.address = next_random();
    r         = next_random();
    p.burst   = r[23:16];
    return p;
  endfunction

  function automatic int unsigned total_requests();
    int unsigned total;
    phase_row_t  row;
    total = 0;
    for (int p = 0; p < num_phases; p++) begin
      row   = phase_row(p);
      total += row.reqs_per_src * mem_req_pkg::num_requestors;
    end
    return total;
  endfunction

  function automatic int unsigned pending_count();
    int unsigned n;
    n = 0;
    for (int i = 0; i < mem_req_pkg::num_requestors; i++) begin
      n += sent[i] - received[i];
    end
    return n;
  endfunction

  task automatic check_request(input string name, input mem_req_pkg::mem_req_tagged_t got,
                               input mem_req_pkg::mem_req_tagged_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_mask(input string name, input mem_req_pkg::requestor_mask_t got,
                            input mem_req_pkg::requestor_mask_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_state(input string name, input mem_req_pkg::fifo_state_t got,
                             input mem_req_pkg::fifo_state_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_source(input string name, input mem_req_pkg::requestor_id_t got,
                              input mem_req_pkg::requestor_id_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // --------------------
  // Output monitor
  // --------------------
  // Falling edge, away from the DUT's rising-edge updates
  always @(negedge ap_clk) begin : monitor
    mem_req_pkg::requestor_id_t   src;
    mem_req_pkg::mem_req_tagged_t exp;
    logic                         all_pending;
    logic                         any_pending;
    last_grant = grant_out;
    if (monitor_on) begin
      all_pending = 1'b1;
      any_pending = 1'b0;
      for (int i = 0; i < mem_req_pkg::num_requestors; i++) begin
        if (sent[i] < cur_row.reqs_per_src) begin
          any_pending = 1'b1;
        end else begin
          all_pending = 1'b0;
        end
        if (sent[i] - received[i] > depth_limit) begin
          error_count++;
          $display("Source %0d has %0d requests outstanding, more than its queues hold",
                   i, sent[i] - received[i]);
        end
      end
      if (phase_active && cur_row.expect_grant_zero && grant_out === '0 && any_pending) begin
        seen_zero = 1'b1;
      end
      if (stall_hold && request_out.valid !== 1'b0) begin
        error_count++;
        $display("Output valid at %0t while rd_en was held low", $time);
      end
      if (request_out.valid === 1'b1) begin
        src = request_out.payload.source;
        if (received[src] >= sent[src]) begin
          error_count++;
          $display("Output from source %0d at %0t with no request pending", src, $time);
        end else begin
          exp.valid          = 1'b1;
          exp.payload.source = src;
          exp.payload.req    = exp_mem[src][received[src]];
          check_request("request_out", request_out, exp);
          // Strict rotation only while every sender still has work
          if (phase_active && cur_row.check_rotation && all_pending && have_prev) begin
            check_source("request_out.payload.source", src,
                         mem_req_pkg::requestor_id_t'(prev_src + 1));
          end
          prev_src      = src;
          have_prev     = 1'b1;
          received[src] = received[src] + 1;
        end
      end
    end
  end

  // --------------------
  // Phases
  // --------------------
  task automatic reset_and_check();
    int unsigned errors_before;
    errors_before = error_count;
    repeat (5) @(posedge ap_clk);
    areset_control <= 1'b0;
    @(negedge ap_clk);
    check_level("request_out.valid", request_out.valid, 1'b0);
    check_mask("grant_out", grant_out, '0);
    check_level("fifo_setup", fifo_setup, 1'b1);
    check_level("fifo_request_state_out.empty", fifo_request_state_out.empty, 1'b1);
    // Watchdog bounds both waits
    while (fifo_setup !== 1'b0) @(negedge ap_clk);
    while (grant_out !== '1) @(negedge ap_clk);
    monitor_on = 1'b1;
    $display("Phase reset     : %0d errors", error_count - errors_before);
  endtask

  task automatic run_phase(input int idx);
    mem_req_pkg::mem_req_payload_t p;
    logic [31:0]                   coin;
    logic                          send;
    logic                          done;
    int unsigned                   cycle;
    int unsigned                   errors_before;
    cur_row       = phase_row(idx);
    errors_before = error_count;
    for (int i = 0; i < mem_req_pkg::num_requestors; i++) begin
      sent[i]     = 0;
      received[i] = 0;
    end
    have_prev    = 1'b0;
    seen_zero    = 1'b0;
    cycle        = 0;
    done         = 1'b0;
    phase_active = 1'b1;
    while (!done) begin
      @(posedge ap_clk);
      done = (cycle + 1 >= cur_row.hold_cycles);
      // One draw per cycle keeps lockstep senders together
      coin = next_random();
      for (int i = 0; i < mem_req_pkg::num_requestors; i++) begin
        if (!cur_row.lockstep) begin
          coin = next_random();
        end
        send = (sent[i] < cur_row.reqs_per_src) && ((coin[31:16] % 100) < cur_row.send_pct);
        send = send && (cur_row.lockstep ? (&last_grant) : last_grant[i]);
        if (send) begin
          p                = random_payload();
          exp_mem[i][sent[i]] = p;
          request_in[i]   <= '{valid: 1'b1, payload: p};
          sent[i]          = sent[i] + 1;
        end else begin
          request_in[i].valid <= 1'b0;
        end
        if (sent[i] < cur_row.reqs_per_src) begin
          done = 1'b0;
        end
      end
      case (cur_row.rd_mode)
        rd_never:     fifo_request_ctrl_in.rd_en <= (cycle >= cur_row.hold_cycles);
        rd_alternate: fifo_request_ctrl_in.rd_en <= (cycle >= cur_row.hold_cycles) | cycle[0];
        default:      fifo_request_ctrl_in.rd_en <= 1'b1;
      endcase
      stall_hold = (cur_row.rd_mode == rd_never) && (cycle < cur_row.hold_cycles);
      cycle++;
    end
    // Drain, then idle to catch extra outputs
    @(posedge ap_clk);
    for (int i = 0; i < mem_req_pkg::num_requestors; i++) begin
      request_in[i].valid <= 1'b0;
    end
    fifo_request_ctrl_in.rd_en <= 1'b1;
    stall_hold = 1'b0;
    while (pending_count() != 0) @(posedge ap_clk);
    repeat (12) @(posedge ap_clk);
    @(negedge ap_clk);
    check_state("fifo_request_state_out", fifo_request_state_out,
                '{empty: 1'b1, full: 1'b0, prog_full: 1'b0, valid: 1'b0});
    check_mask("grant_out", grant_out, '1);
    if (cur_row.expect_grant_zero && !seen_zero) begin
      error_count++;
      $display("grant_out never fell to zero while senders still held requests");
    end
    for (int i = 0; i < mem_req_pkg::num_requestors; i++) begin
      if (sent[i] != cur_row.reqs_per_src || received[i] != sent[i]) begin
        error_count++;
        $display("Source %0d sent %0d and received %0d of %0d requests",
                 i, sent[i], received[i], cur_row.reqs_per_src);
      end
    end
    phase_active = 1'b0;
    $display("Phase %s: %0d requests, %0d errors", cur_row.name,
             cur_row.reqs_per_src * mem_req_pkg::num_requestors, error_count - errors_before);
  endtask

  initial begin : main
    areset_control       = 1'b1;
    fifo_request_ctrl_in = '0;
    for (int i = 0; i < mem_req_pkg::num_requestors; i++) begin
      request_in[i] = '0;
      sent[i]       = 0;
      received[i]   = 0;
    end
    cur_row      = '0;
    last_grant   = '0;
    prev_src     = '0;
    have_prev    = 1'b0;
    seen_zero    = 1'b0;
    stall_hold   = 1'b0;
    monitor_on   = 1'b0;
    phase_active = 1'b0;
    lcg_state    = 32'h31fc;
    check_count  = 0;
    error_count  = 0;
    reset_and_check();
    for (int p = 0; p < num_phases; p++) begin
      run_phase(p);
    end
    $display("Summary: %0d phases, %0d checks, %0d errors", num_phases + 1, check_count,
             error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // 64 cycles per request plus room for reset and the idle tails
  initial begin : watchdog
    int unsigned limit_cycles;
    limit_cycles = total_requests() * 64 + 2000;
    repeat (limit_cycles) @(posedge ap_clk);
    $display("Timeout after %0d cycles, the run did not finish", limit_cycles);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+test
rtl/mem_req_pkg.sv
rtl/request_fifo.sv
rtl/arbiter_control.sv
rtl/request_merge.sv
rtl/memory_request_arbiter.sv
test/tb_memory_request_arbiter.sv

//--- Bender.yml
package:
  name: memory_request_arbiter

sources:
  - rtl/mem_req_pkg.sv
  - rtl/request_fifo.sv
  - rtl/arbiter_control.sv
  - rtl/request_merge.sv
  - rtl/memory_request_arbiter.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_memory_request_arbiter.sv
